//--- rf_pkg.sv
// Register file package with the array widths and the shared word typedefs
package rf_pkg;

    // ------------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------------

    // Five address bits index the 32 entries of the array
    parameter int rf_addr_w = 5;

    // User data width as seen on the outside write and read ports
    parameter int rf_data_w = 32;

    // A stored word is the user data with one parity bit on top
    parameter int rf_word_w = rf_data_w + 1;

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------

    // Entry index into the array
    typedef logic [rf_addr_w-1:0] rf_addr_t;

    // User data word without parity
    typedef logic [rf_data_w-1:0] rf_data_t;

    // Stored word with the parity bit at the top
    // The parity bit makes the XOR of all 33 bits zero (even parity)
    typedef logic [rf_word_w-1:0] rf_word_t;

endpackage

//--- rf_mem_32x33.sv
// Behavioral 32x33 two-port storage array with a registered, isolation-cleared read port
`timescale 1ns/100ps

module rf_mem_32x33 (
     input  logic             clk
    ,input  logic             we
    ,input  rf_pkg::rf_addr_t waddr
    ,input  rf_pkg::rf_word_t wdata
    ,input  logic             re
    ,input  rf_pkg::rf_addr_t raddr
    ,input  logic             isol_en
    ,output rf_pkg::rf_word_t rdata
);

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    // One word per address, 2**rf_addr_w entries deep
    rf_pkg::rf_word_t mem [2**rf_pkg::rf_addr_w];

    // Write port stores the word on the clock edge when we is high
    // The wrapper has already removed we while the array is off
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------

    // The read register loads on re and holds between reads
    // While isolation is on the outputs are clamped, so the register
    // clears to zero and never drives array contents out of the block
    always_ff @(posedge clk) begin
        if (isol_en) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- rf_pg_wrap_32x33.sv
// Power-gated wrapper that runs the power enable through a chain and gates array access
`timescale 1ns/100ps

module rf_pg_wrap_32x33 #(
    parameter int pg_chain_len = 4
) (
     input  logic             clk
    ,input  logic             rst
    ,input  logic             we
    ,input  rf_pkg::rf_addr_t waddr
    ,input  rf_pkg::rf_word_t wdata
    ,input  logic             re
    ,input  rf_pkg::rf_addr_t raddr
    ,output rf_pkg::rf_word_t rdata
    // Power interface
    ,input  logic             isol_en
    ,input  logic             pwr_enable_b
    ,output logic             pwr_enable_b_out
);

    // ------------------------------------------------------------------
    // Power enable chain
    // ------------------------------------------------------------------

    // Each stage models one switch bank of the array turning on in turn
    // All stages come out of reset high so the array starts off
    logic [pg_chain_len-1:0] pwr_chain;

    // High while the last bank shows the array on
    logic array_on;

    always_ff @(posedge clk) begin
        if (rst) begin
            pwr_chain <= '1;
        end else begin
            pwr_chain[0] <= pwr_enable_b;
            for (int i = 1; i < pg_chain_len; i++) begin
                pwr_chain[i] <= pwr_chain[i-1];
            end
        end
    end

    // The controller waits on this before it trusts the array
    assign pwr_enable_b_out = pwr_chain[pg_chain_len-1];
    assign array_on         = ~pwr_enable_b_out;

    // ------------------------------------------------------------------
    // Array
    // ------------------------------------------------------------------

    // Accesses reach the array only once the whole chain shows it on
    rf_mem_32x33 i_rf (
         .clk     (clk)
        ,.we      (we & array_on)
        ,.waddr   (waddr)
        ,.wdata   (wdata)
        ,.re      (re & array_on)
        ,.raddr   (raddr)
        ,.isol_en (isol_en)
        ,.rdata   (rdata)
    );

endmodule

//--- rf_power_ctrl.sv
// Power controller FSM that turns a four-phase req/ack into isolation and enable sequencing
`timescale 1ns/100ps

module rf_power_ctrl (
     input  logic clk
    ,input  logic rst
    ,input  logic pwr_req
    ,input  logic pwr_enable_b_out
    ,output logic pwr_ack
    ,output logic pwr_enable_b
    ,output logic isol_en
    ,output logic powered
);

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        st_off,
        st_waking,
        st_on,
        st_sleeping
    } pwr_state_t;

    pwr_state_t state;

    // ------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------

    // All outputs are registered so the array sees clean edges
    // Power-up order is enable low, chain done, isolation off, powered and ack
    // Power-down runs the same steps backwards
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_off;
            pwr_ack      <= 1'b0;
            pwr_enable_b <= 1'b1;
            isol_en      <= 1'b1;
            powered      <= 1'b0;
        end else begin
            case (state)
                st_off: begin
                    // Rising request starts the first bank turning on
                    if (pwr_req) begin
                        pwr_enable_b <= 1'b0;
                        state        <= st_waking;
                    end
                end
                st_waking: begin
                    // Isolation stays on until every bank is up
                    if (!pwr_enable_b_out) begin
                        if (isol_en) begin
                            isol_en <= 1'b0;
                        end else begin
                            // Outputs are live one cycle before users may access
                            powered <= 1'b1;
                            pwr_ack <= 1'b1;
                            state   <= st_on;
                        end
                    end
                end
                st_on: begin
                    // Stop new accesses first; ones already taken finish
                    // on the next edge while the array is still fully on
                    if (!pwr_req) begin
                        powered <= 1'b0;
                        state   <= st_sleeping;
                    end
                end
                st_sleeping: begin
                    if (!isol_en) begin
                        isol_en <= 1'b1;
                    end else if (!pwr_enable_b) begin
                        pwr_enable_b <= 1'b1;
                    end else if (pwr_enable_b_out) begin
                        // Last bank is off, so the handshake can close
                        pwr_ack <= 1'b0;
                        state   <= st_off;
                    end
                end
                default: begin
                    state <= st_off;
                end
            endcase
        end
    end

endmodule

//--- rf_access_ctrl.sv
// Access controller with parity generation, write drop, read tracking and error flags
`timescale 1ns/100ps

module rf_access_ctrl (
     input  logic             clk
    ,input  logic             rst
    ,input  logic             powered
    // Outside write port
    ,input  logic             wr_en
    ,input  rf_pkg::rf_addr_t wr_addr
    ,input  rf_pkg::rf_data_t wr_data
    ,input  logic             par_inject
    ,output logic             wr_drop
    // Outside read port
    ,input  logic             rd_en
    ,input  rf_pkg::rf_addr_t rd_addr
    ,output logic             rd_valid
    ,output rf_pkg::rf_data_t rd_data
    ,output logic             rd_par_err
    ,output logic             rd_sleep_err
    // Array side
    ,output logic             we
    ,output rf_pkg::rf_addr_t waddr
    ,output rf_pkg::rf_word_t wdata
    ,output logic             re
    ,output rf_pkg::rf_addr_t raddr
    ,input  rf_pkg::rf_word_t rdata
);

    // ------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------

    // Even parity bit over the data that par_inject flips to plant a bad word
    logic wr_par;
    // Marks a write that arrived while the array was down so wr_drop follows a cycle later
    logic wr_drop_q;

    assign wr_par = (^wr_data) ^ par_inject;

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------

    // Stage 1 lines up with the array read, stage 2 with the read register
    logic rd_v1;
    logic rd_v2;
    // Power state at the time each read was taken
    logic rd_pw1;
    logic rd_pw2;

    // Control and valid pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            we           <= 1'b0;
            wr_drop_q    <= 1'b0;
            wr_drop      <= 1'b0;
            re           <= 1'b0;
            rd_v1        <= 1'b0;
            rd_v2        <= 1'b0;
            rd_pw1       <= 1'b0;
            rd_pw2       <= 1'b0;
            rd_valid     <= 1'b0;
            rd_par_err   <= 1'b0;
            rd_sleep_err <= 1'b0;
        end else begin
            we        <= wr_en & powered;
            wr_drop_q <= wr_en & ~powered;
            wr_drop   <= wr_drop_q;
            // No array read is issued when the array is down
            re        <= rd_en & powered;
            rd_v1     <= rd_en;
            rd_pw1    <= powered;
            rd_v2     <= rd_v1;
            rd_pw2    <= rd_pw1;
            rd_valid  <= rd_v2;
            // A whole 33-bit word with odd parity is a bad word
            rd_par_err   <= rd_v2 & rd_pw2 & (^rdata);
            rd_sleep_err <= rd_v2 & ~rd_pw2;
        end
    end

    // Address and data registers load on every cycle
    always_ff @(posedge clk) begin
        waddr <= wr_addr;
        wdata <= {wr_par, wr_data};
        raddr <= rd_addr;
        // Reads taken while down return zero whatever the array holds
        if (rd_pw2) begin
            rd_data <= rdata[rf_pkg::rf_data_w-1:0];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- rf_subsys.sv
// Register file subsystem top joining power control, the gated array and access control
`timescale 1ns/100ps

module rf_subsys #(
    parameter int pg_chain_len = 4
) (
     input  logic             clk
    ,input  logic             rst
    // Power handshake
    ,input  logic             pwr_req
    ,output logic             pwr_ack
    // Write port
    ,input  logic             wr_en
    ,input  rf_pkg::rf_addr_t wr_addr
    ,input  rf_pkg::rf_data_t wr_data
    ,input  logic             par_inject
    ,output logic             wr_drop
    // Read port
    ,input  logic             rd_en
    ,input  rf_pkg::rf_addr_t rd_addr
    ,output logic             rd_valid
    ,output rf_pkg::rf_data_t rd_data
    ,output logic             rd_par_err
    ,output logic             rd_sleep_err
);

    // ------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------

    // Power control to and from the wrapper
    logic             pwr_enable_b;
    logic             pwr_enable_b_out;
    logic             isol_en;
    logic             powered;
    // Access control to and from the array
    logic             we;
    rf_pkg::rf_addr_t waddr;
    rf_pkg::rf_word_t wdata;
    logic             re;
    rf_pkg::rf_addr_t raddr;
    rf_pkg::rf_word_t rdata;

    rf_power_ctrl i_pwr_ctrl (
         .clk              (clk)
        ,.rst              (rst)
        ,.pwr_req          (pwr_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_ack          (pwr_ack)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.isol_en          (isol_en)
        ,.powered          (powered)
    );

    rf_pg_wrap_32x33 #(
        .pg_chain_len (pg_chain_len)
    ) i_rf_wrap (
         .clk              (clk)
        ,.rst              (rst)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    rf_access_ctrl i_acc_ctrl (
         .clk          (clk)
        ,.rst          (rst)
        ,.powered      (powered)
        ,.wr_en        (wr_en)
        ,.wr_addr      (wr_addr)
        ,.wr_data      (wr_data)
        ,.par_inject   (par_inject)
        ,.wr_drop      (wr_drop)
        ,.rd_en        (rd_en)
        ,.rd_addr      (rd_addr)
        ,.rd_valid     (rd_valid)
        ,.rd_data      (rd_data)
        ,.rd_par_err   (rd_par_err)
        ,.rd_sleep_err (rd_sleep_err)
        ,.we           (we)
        ,.waddr        (waddr)
        ,.wdata        (wdata)
        ,.re           (re)
        ,.raddr        (raddr)
        ,.rdata        (rdata)
    );

endmodule

//--- tb_rf_subsys.sv
// Self-checking testbench for the power-gated register file subsystem
`timescale 1ns/100ps

module tb_rf_subsys;

    localparam int pg_len    = 4;
    localparam int num_steps = 18;

    logic             clk;
    logic             rst;
    logic             pwr_req;
    logic             pwr_ack;
    logic             wr_en;
    rf_pkg::rf_addr_t wr_addr;
    rf_pkg::rf_data_t wr_data;
    logic             par_inject;
    logic             wr_drop;
    logic             rd_en;
    rf_pkg::rf_addr_t rd_addr;
    logic             rd_valid;
    rf_pkg::rf_data_t rd_data;
    logic             rd_par_err;
    logic             rd_sleep_err;

    rf_subsys #(.pg_chain_len(pg_len)) dut (.*);

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        op_pwr_up, op_pwr_down, op_write, op_write_inj, op_read, op_read2
    } op_t;

    // Expected flag bits with drop for writes and sleep and parity for reads
    localparam logic [2:0] f_none  = 3'b000;
    localparam logic [2:0] f_drop  = 3'b100;
    localparam logic [2:0] f_sleep = 3'b010;
    localparam logic [2:0] f_par   = 3'b001;

    typedef struct packed {
        op_t              op;
        rf_pkg::rf_addr_t addr;
        logic [2:0]       flags;
    } step_t;

    // A two-read step reads addr and addr+1 on back-to-back cycles
    step_t steps [num_steps] = '{
        '{op_read, 5'd3, f_sleep},   '{op_write, 5'd3, f_drop},
        '{op_pwr_up, 5'd0, f_none},  '{op_write, 5'd5, f_none},
        '{op_write, 5'd17, f_none},  '{op_write, 5'd18, f_none},
        '{op_read, 5'd5, f_none},    '{op_read2, 5'd17, f_none},
        '{op_write_inj, 5'd9, f_none}, '{op_read, 5'd9, f_par},
        '{op_pwr_down, 5'd0, f_none}, '{op_read2, 5'd17, f_sleep},
        '{op_write, 5'd5, f_drop},   '{op_pwr_up, 5'd0, f_none},
        '{op_write, 5'd5, f_none},   '{op_read, 5'd5, f_none},
        '{op_pwr_down, 5'd0, f_none}, '{op_read, 5'd5, f_sleep}
    };

    // Data last written to each entry while powered
    rf_pkg::rf_data_t ref_data [32];
    logic [31:0]      lfsr_state;
    int               n_checks;
    int               n_errors;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_data(output rf_pkg::rf_data_t d);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            d[b] = lfsr_state[0];
        end
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // The controller sees the new request one edge later, so ack cannot follow at once
    task automatic handshake(input string name, input bit level);
        int cycles;
        cycles = 0;
        @(posedge clk);
        pwr_req <= level;
        @(negedge clk);
        compare({name, " pwr_ack early"}, 32'(!level), 32'(pwr_ack));
        while (pwr_ack !== level && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (pwr_ack !== level || cycles < pg_len + 1) begin
            n_errors++;
            $display("%s: power handshake missing or too short after %0d cycles", name, cycles);
        end
    endtask

    // The DUT samples the write one edge after the drive and wr_drop shows one edge later
    task automatic write_word(input string name, input rf_pkg::rf_addr_t addr, input bit inject,
                              input bit exp_drop);
        rf_pkg::rf_data_t d;
        draw_data(d);
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            wr_en      <= (k == 0);
            wr_addr    <= addr;
            wr_data    <= d;
            par_inject <= inject && (k == 0);
            @(negedge clk);
            compare({name, " wr_drop"}, 32'(exp_drop && k == 2), 32'(wr_drop));
        end
        if (!exp_drop) begin
            ref_data[addr] = d;
        end
    endtask

    // Read j is driven at edge k=j and must show valid after edge k=j+3
    task automatic read_back(input string name, input rf_pkg::rf_addr_t addr, input int n,
                             input bit exp_sleep, input bit exp_par);
        rf_pkg::rf_addr_t a;
        int j;
        for (int k = 0; k < n + 4; k++) begin
            @(posedge clk);
            a = addr + 5'(k);
            rd_en   <= (k < n);
            rd_addr <= a;
            @(negedge clk);
            j = k - 3;
            compare({name, " rd_valid"}, 32'(j >= 0 && j < n), 32'(rd_valid));
            if (j >= 0 && j < n) begin
                a = addr + 5'(j);
                compare({name, " rd_data"}, exp_sleep ? 32'd0 : ref_data[a], rd_data);
                compare({name, " rd_par_err"}, 32'(exp_par), 32'(rd_par_err));
                compare({name, " rd_sleep_err"}, 32'(exp_sleep), 32'(rd_sleep_err));
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------

    initial begin
        step_t st;
        string nm;
        n_checks   = 0;
        n_errors   = 0;
        lfsr_state = 32'hec0e_6d71;
        rst        = 1'b1;
        pwr_req    = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        par_inject = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Array stays off with no request pending
        repeat (3) begin
            @(negedge clk);
            compare("reset pwr_ack", 32'd0, 32'(pwr_ack));
            compare("reset rd_valid", 32'd0, 32'(rd_valid));
            compare("reset wr_drop", 32'd0, 32'(wr_drop));
        end
        for (int i = 0; i < num_steps; i++) begin
            st = steps[i];
            nm = $sformatf("step %0d", i);
            case (st.op)
                op_pwr_up:    handshake(nm, 1'b1);
                op_pwr_down:  handshake(nm, 1'b0);
                op_write:     write_word(nm, st.addr, 1'b0, st.flags[2]);
                op_write_inj: write_word(nm, st.addr, 1'b1, st.flags[2]);
                op_read:      read_back(nm, st.addr, 1, st.flags[1], st.flags[0]);
                default:      read_back(nm, st.addr, 2, st.flags[1], st.flags[0]);
            endcase
        end
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (num_steps * 200) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", num_steps * 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- project.f
rf_pkg.sv
rf_mem_32x33.sv
rf_pg_wrap_32x33.sv
rf_power_ctrl.sv
rf_access_ctrl.sv
rf_subsys.sv
tb_rf_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module tb_rf_subsys -o tb_rf_subsys \
    && ./obj_dir/tb_rf_subsys | tee sim.log
grep -qx '>>> PASS' sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
